// ==== rtl/ld_buffer.sv ====
// --------------------------------------
// outstanding load buffer
// one slot per request id, written at the grant
// and freed by the response carrying that id
// --------------------------------------
`default_nettype none
`timescale 1ns/1ps

module ld_buffer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     we_i,
  input  ld_op_pkg::ldbuf_entry_t  wentry_i,
  input  logic                     rvalid_i,
  input  ld_cfg_pkg::ldbuf_id_t    rid_i,
  output logic                     full_o,
  output ld_cfg_pkg::ldbuf_id_t    wid_o,
  output ld_op_pkg::ldbuf_entry_t  rentry_o,
  output logic                     rlive_o
);
  import ld_cfg_pkg::*;
  import ld_op_pkg::*;

  ldbuf_entry_t                mem_q [NR_LDBUF];
  logic [NR_LDBUF-1:0]         valid_d, valid_q;
  logic [NR_LDBUF-1:0]         flushed_d, flushed_q;

  assign full_o = &valid_q;

  // lowest free slot, scanning down so slot 0 wins
  always_comb begin
    wid_o = '0;
    for (int i = NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        wid_o = ldbuf_id_t'(i);
      end
    end
  end

  // --------------------------------------
  // slot flags
  // --------------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // everything in flight becomes stale
    if (flush_i) begin
      flushed_d = '1;
    end
    // response retires its slot
    if (rvalid_i) begin
      valid_d[rid_i] = 1'b0;
    end
    // new load starts clean even during a flush
    if (we_i) begin
      valid_d[wid_o]   = 1'b1;
      flushed_d[wid_o] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[wid_o] <= wentry_i;
    end
  end

  // combinational read at the response id
  assign rentry_o = mem_q[rid_i];
  assign rlive_o  = rvalid_i && !flushed_q[rid_i];

  // word loads must fit in the 64-bit line word
  offset_word_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    we_i && (wentry_i.op inside {LW, LWU}) |-> wentry_i.offset < 5)
    else $error("misaligned word load offset %0d", wentry_i.offset);
  // half loads likewise
  offset_half_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    we_i && (wentry_i.op inside {LH, LHU}) |-> wentry_i.offset < 7)
    else $error("misaligned half load offset %0d", wentry_i.offset);
  // request side must respect back-pressure
  no_write_full_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    we_i |-> !full_o)
    else $error("load buffer written while full");
  // cache answers only ids it was given
  no_resp_free_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> valid_q[rid_i])
    else $error("response for free slot %0d", rid_i);

endmodule

`default_nettype wire

// ==== rtl/ld_cfg_pkg.sv ====
// --------------------------------------
// load unit size configuration
// widths of data, address, ids and cache fields
// --------------------------------------
`default_nettype none

package ld_cfg_pkg;

  // datapath and address
  localparam int unsigned XLEN       = 64;
  localparam int unsigned VLEN       = 39;
  // outstanding loads and their ids
  localparam int unsigned NR_LDBUF   = 4;
  localparam int unsigned LDBUF_ID_W = $clog2(NR_LDBUF);
  localparam int unsigned TRANS_ID_W = 3;
  // byte offset inside one data word
  localparam int unsigned ALIGN_W    = $clog2(XLEN / 8);
  // cache address split, the tag is what is left above the index
  localparam int unsigned INDEX_W    = 12;
  localparam int unsigned TAG_W      = VLEN - INDEX_W;

  typedef logic [LDBUF_ID_W-1:0] ldbuf_id_t;
  typedef logic [TRANS_ID_W-1:0] trans_id_t;

endpackage

`default_nettype wire

// ==== rtl/ld_op_pkg.sv ====
// --------------------------------------
// load operation definitions
// operation codes, transfer sizes and the
// record kept per outstanding load
// --------------------------------------
`default_nettype none

package ld_op_pkg;

  // load flavours, U marks zero extension
  typedef enum logic [2:0] {
    LD  = 3'd0,
    LW  = 3'd1,
    LWU = 3'd2,
    LH  = 3'd3,
    LHU = 3'd4,
    LB  = 3'd5,
    LBU = 3'd6
  } ld_op_e;

  // log2 of the number of bytes moved
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } size_t;

  // one outstanding load, 9 bits wide
  typedef struct packed {
    ld_cfg_pkg::trans_id_t              trans_id;
    logic [ld_cfg_pkg::ALIGN_W-1:0]     offset;
    ld_op_e                             op;
  } ldbuf_entry_t;

  // transfer size requested from the cache
  function automatic size_t op_size(ld_op_e op);
    case (op)
      LD:       return SIZE_D;
      LW, LWU:  return SIZE_W;
      LH, LHU:  return SIZE_H;
      default:  return SIZE_B;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== rtl/ld_req_fsm.sv ====
// --------------------------------------
// load request state machine
// waits for store offset clear and cache grant,
// sends the tag one cycle after the grant and
// kills the tag after a flush
// --------------------------------------
`default_nettype none
`timescale 1ns/1ps

module ld_req_fsm (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  input  logic                             valid_i,
  input  logic [ld_cfg_pkg::VLEN-1:0]      vaddr_i,
  input  ld_op_pkg::ld_op_e                op_i,
  input  logic                             page_offset_matches_i,
  input  logic                             gnt_i,
  input  logic                             ldbuf_full_i,
  output logic                             pop_o,
  output logic                             req_o,
  output ld_op_pkg::size_t                 size_o,
  output logic [ld_cfg_pkg::INDEX_W-1:0]   index_o,
  output logic [ld_cfg_pkg::TAG_W-1:0]     tag_o,
  output logic                             tag_valid_o,
  output logic                             kill_o,
  output logic                             ldbuf_we_o
);
  import ld_cfg_pkg::*;
  import ld_op_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_PAGE_OFFSET,
    WAIT_GNT,
    SEND_TAG,
    WAIT_FLUSH
  } state_e;

  state_e             state_d, state_q;
  logic               accept_req;
  logic [TAG_W-1:0]   tag_q;

  // a new load may start only with room in the buffer
  assign accept_req = valid_i && !ldbuf_full_i;

  // index goes out with the request and the tag a cycle later
  assign index_o    = vaddr_i[INDEX_W-1:0];
  assign size_o     = op_size(op_i);
  assign tag_o      = tag_q;
  // every granted request is tracked in the load buffer
  assign ldbuf_we_o = req_o && gnt_i;

  // --------------------------------------
  // next state and outputs
  // --------------------------------------
  always_comb begin
    state_d     = state_q;
    req_o       = 1'b0;
    pop_o       = 1'b0;
    tag_valid_o = 1'b0;
    kill_o      = 1'b0;

    case (state_q)
      // send tag overlaps with the start of the next load
      IDLE, SEND_TAG: begin
        tag_valid_o = (state_q == SEND_TAG);
        state_d     = IDLE;
        if (accept_req) begin
          if (page_offset_matches_i) begin
            // store to the same offset still pending
            state_d = WAIT_PAGE_OFFSET;
          end else begin
            req_o = 1'b1;
            if (gnt_i) begin
              pop_o   = 1'b1;
              state_d = SEND_TAG;
            end else begin
              state_d = WAIT_GNT;
            end
          end
        end
      end

      // request is raised only once the offset clears
      WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) begin
          state_d = WAIT_GNT;
        end
      end

      // hold the request until the cache grants it
      WAIT_GNT: begin
        req_o = 1'b1;
        if (gnt_i) begin
          pop_o   = 1'b1;
          state_d = SEND_TAG;
        end
      end

      // drop whatever tag phase the cache is expecting
      WAIT_FLUSH: begin
        tag_valid_o = 1'b1;
        kill_o      = 1'b1;
        state_d     = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // flush wins over any other transition
    if (flush_i) begin
      state_d = WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // upper address bits caught at the grant as the physical tag
  always_ff @(posedge clk_i) begin
    if (ldbuf_we_o) begin
      tag_q <= vaddr_i[VLEN-1:INDEX_W];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ld_result_align.sv ====
// --------------------------------------
// load result aligner
// shifts the response word to the load offset
// and sign or zero extends it
// --------------------------------------
`default_nettype none
`timescale 1ns/1ps

module ld_result_align (
  input  logic [ld_cfg_pkg::XLEN-1:0]  rdata_i,
  input  ld_op_pkg::ldbuf_entry_t      entry_i,
  input  logic                         live_i,
  output logic                         valid_o,
  output ld_cfg_pkg::trans_id_t        trans_id_o,
  output logic [ld_cfg_pkg::XLEN-1:0]  result_o
);
  import ld_cfg_pkg::*;
  import ld_op_pkg::*;

  logic [XLEN-1:0]     shifted_data;
  logic [XLEN/8-1:0]   sign_bits;
  logic [ALIGN_W-1:0]  sign_idx;
  logic                is_signed;
  logic                sign_bit;

  assign valid_o    = live_i;
  assign trans_id_o = entry_i.trans_id;

  // byte offset times eight
  assign shifted_data = rdata_i >> {entry_i.offset, 3'b000};

  // top bit of every byte of the raw word
  for (genvar i = 0; i < XLEN / 8; i++) begin : gen_sign_bits
    assign sign_bits[i] = rdata_i[8*i+7];
  end

  // highest byte of the loaded field, picked beside the shifter
  always_comb begin
    case (entry_i.op)
      LW, LWU: sign_idx = entry_i.offset + ALIGN_W'(3);
      LH, LHU: sign_idx = entry_i.offset + ALIGN_W'(1);
      default: sign_idx = entry_i.offset;
    endcase
  end

  assign is_signed = entry_i.op inside {LW, LH, LB};
  // unsigned loads pull the sign to zero
  assign sign_bit  = is_signed && sign_bits[sign_idx];

  // --------------------------------------
  // extension mux
  // --------------------------------------
  always_comb begin
    case (entry_i.op)
      LW, LWU: result_o = {{XLEN-32{sign_bit}}, shifted_data[31:0]};
      LH, LHU: result_o = {{XLEN-16{sign_bit}}, shifted_data[15:0]};
      LB, LBU: result_o = {{XLEN-8{sign_bit}}, shifted_data[7:0]};
      // full double word
      default: result_o = shifted_data;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/load_unit_top.sv ====
// --------------------------------------
// data cache load unit
// request FSM and outstanding load buffer side
// by side, aligner on the response path
// --------------------------------------
`default_nettype none
`timescale 1ns/1ps

module load_unit_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  // load request, held until pop
  input  logic                             valid_i,
  input  logic [ld_cfg_pkg::VLEN-1:0]      vaddr_i,
  input  ld_op_pkg::ld_op_e                op_i,
  input  ld_cfg_pkg::trans_id_t            trans_id_i,
  output logic                             pop_o,
  // store offset check
  output logic [11:0]                      page_offset_o,
  input  logic                             page_offset_matches_i,
  // cache request
  output logic                             req_o,
  input  logic                             gnt_i,
  output logic [ld_cfg_pkg::INDEX_W-1:0]   index_o,
  output logic [ld_cfg_pkg::TAG_W-1:0]     tag_o,
  output logic                             tag_valid_o,
  output logic                             kill_o,
  output ld_op_pkg::size_t                 size_o,
  output ld_cfg_pkg::ldbuf_id_t            id_o,
  // cache response, out of order
  input  logic                             rvalid_i,
  input  ld_cfg_pkg::ldbuf_id_t            rid_i,
  input  logic [ld_cfg_pkg::XLEN-1:0]      rdata_i,
  // retired load
  output logic                             valid_o,
  output ld_cfg_pkg::trans_id_t            trans_id_o,
  output logic [ld_cfg_pkg::XLEN-1:0]      result_o
);
  import ld_cfg_pkg::*;
  import ld_op_pkg::*;

  logic          ldbuf_full;
  logic          ldbuf_we;
  ldbuf_id_t     ldbuf_wid;
  ldbuf_entry_t  ldbuf_wentry;
  ldbuf_entry_t  ldbuf_rentry;
  logic          ldbuf_rlive;

  // store unit compares against the 4 KiB page offset
  assign page_offset_o = vaddr_i[11:0];
  // cache request id is the buffer slot
  assign id_o          = ldbuf_wid;
  assign ldbuf_wentry  = '{trans_id: trans_id_i, offset: vaddr_i[ALIGN_W-1:0], op: op_i};

  ld_req_fsm i_req_fsm (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .vaddr_i               (vaddr_i),
    .op_i                  (op_i),
    .page_offset_matches_i (page_offset_matches_i),
    .gnt_i                 (gnt_i),
    .ldbuf_full_i          (ldbuf_full),
    .pop_o                 (pop_o),
    .req_o                 (req_o),
    .size_o                (size_o),
    .index_o               (index_o),
    .tag_o                 (tag_o),
    .tag_valid_o           (tag_valid_o),
    .kill_o                (kill_o),
    .ldbuf_we_o            (ldbuf_we)
  );

  ld_buffer i_ld_buffer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .flush_i  (flush_i),
    .we_i     (ldbuf_we),
    .wentry_i (ldbuf_wentry),
    .rvalid_i (rvalid_i),
    .rid_i    (rid_i),
    .full_o   (ldbuf_full),
    .wid_o    (ldbuf_wid),
    .rentry_o (ldbuf_rentry),
    .rlive_o  (ldbuf_rlive)
  );

  ld_result_align i_result_align (
    .rdata_i    (rdata_i),
    .entry_i    (ldbuf_rentry),
    .live_i     (ldbuf_rlive),
    .valid_o    (valid_o),
    .trans_id_o (trans_id_o),
    .result_o   (result_o)
  );

endmodule

`default_nettype wire

// ==== tests/tb_load_unit.sv ====
// --------------------------------------
// load unit testbench
// directed tests with a cache model that
// grants, answers out of order and checks
// --------------------------------------
`default_nettype none
`timescale 1ns/1ps

module tb_load_unit;
  import ld_cfg_pkg::*;
  import ld_op_pkg::*;

  logic                clk_i;
  logic                rst_ni;
  logic                flush_i;
  logic                valid_i;
  logic [VLEN-1:0]     vaddr_i;
  ld_op_e              op_i;
  trans_id_t           trans_id_i;
  logic                pop_o;
  logic [11:0]         page_offset_o;
  logic                page_offset_matches_i;
  logic                req_o;
  logic                gnt_i;
  logic [INDEX_W-1:0]  index_o;
  logic [TAG_W-1:0]    tag_o;
  logic                tag_valid_o;
  logic                kill_o;
  size_t               size_o;
  ldbuf_id_t           id_o;
  logic                rvalid_i;
  ldbuf_id_t           rid_i;
  logic [XLEN-1:0]     rdata_i;
  logic                valid_o;
  trans_id_t           trans_id_o;
  logic [XLEN-1:0]     result_o;

  // cache model view of every granted load per request id
  logic [VLEN-1:0]     pend_addr [NR_LDBUF];
  ld_op_e              pend_op [NR_LDBUF];
  trans_id_t           pend_tid [NR_LDBUF];

  trans_id_t           next_tid;
  int                  n_checks;
  int                  n_errors;

  load_unit_top i_dut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .vaddr_i               (vaddr_i),
    .op_i                  (op_i),
    .trans_id_i            (trans_id_i),
    .pop_o                 (pop_o),
    .page_offset_o         (page_offset_o),
    .page_offset_matches_i (page_offset_matches_i),
    .req_o                 (req_o),
    .gnt_i                 (gnt_i),
    .index_o               (index_o),
    .tag_o                 (tag_o),
    .tag_valid_o           (tag_valid_o),
    .kill_o                (kill_o),
    .size_o                (size_o),
    .id_o                  (id_o),
    .rvalid_i              (rvalid_i),
    .rid_i                 (rid_i),
    .rdata_i               (rdata_i),
    .valid_o               (valid_o),
    .trans_id_o            (trans_id_o),
    .result_o              (result_o)
  );

  // 100 ns period
  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // --------------------------------------
  // reference model and helpers
  // --------------------------------------
  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
      n_errors++;
    end
  endtask

  // field at 8*offset with the width of the operation and extended per U suffix
  function automatic logic [63:0] expected_result(input logic [63:0] data, input int off,
                                                  input ld_op_e op);
    logic [63:0] field;
    logic [63:0] mask;
    int          nbytes;
    case (op)
      LD:       nbytes = 8;
      LW, LWU:  nbytes = 4;
      LH, LHU:  nbytes = 2;
      default:  nbytes = 1;
    endcase
    field = data >> (8 * off);
    if (nbytes == 8) return field;
    mask  = (64'd1 << (8 * nbytes)) - 64'd1;
    field = field & mask;
    if ((op == LW || op == LH || op == LB) && field[8*nbytes-1]) begin
      field = field | ~mask;
    end
    return field;
  endfunction

  // log2 of the byte count
  function automatic int expected_size(input ld_op_e op);
    case (op)
      LD:       return 3;
      LW, LWU:  return 2;
      LH, LHU:  return 1;
      default:  return 0;
    endcase
  endfunction

  function automatic logic [VLEN-1:0] random_addr(input int off);
    logic [VLEN-1:0] a;
    a = VLEN'({$urandom, $urandom});
    a[ALIGN_W-1:0] = off[ALIGN_W-1:0];
    return a;
  endfunction

  task automatic wait_req(input int limit);
    int n;
    n = 0;
    #1;
    while (!req_o && n < limit) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!req_o) begin
      $display("timeout: req_o stayed low for %0d cycles", limit);
      n_errors++;
    end
  endtask

  // put a load on the request port and preset the grant when there is no delay
  task automatic start_load(input logic [VLEN-1:0] addr, input ld_op_e op, input int gnt_delay);
    @(negedge clk_i);
    valid_i    = 1'b1;
    vaddr_i    = addr;
    op_i       = op;
    trans_id_i = next_tid;
    next_tid++;
    gnt_i      = (gnt_delay == 0);
  endtask

  // entered at a falling edge and left in the tag cycle
  task automatic complete_load(input int gnt_delay, output ldbuf_id_t id);
    wait_req(16);
    for (int k = 0; k < gnt_delay; k++) begin
      check("req_o", req_o, 1);
      check("pop_o", pop_o, 0);
      @(negedge clk_i);
      gnt_i = (k == gnt_delay - 1);
      #1;
    end
    // grant cycle
    check("pop_o", pop_o, 1);
    check("size_o", size_o, expected_size(op_i));
    check("index_o", index_o, vaddr_i[INDEX_W-1:0]);
    id = id_o;
    pend_addr[id] = vaddr_i;
    pend_op[id]   = op_i;
    pend_tid[id]  = trans_id_i;
    @(negedge clk_i);
    valid_i = 1'b0;
    gnt_i   = 1'b0;
    #1;
    check("tag_valid_o", tag_valid_o, 1);
    check("kill_o", kill_o, 0);
    check("tag_o", tag_o, pend_addr[id][VLEN-1:INDEX_W]);
  endtask

  task automatic issue_load(input logic [VLEN-1:0] addr, input ld_op_e op,
                            input int gnt_delay, output ldbuf_id_t id);
    start_load(addr, op, gnt_delay);
    complete_load(gnt_delay, id);
  endtask

  // cache answer for one id with a random data word
  task automatic respond(input ldbuf_id_t id, input logic live);
    logic [XLEN-1:0] data;
    data = {$urandom, $urandom};
    @(negedge clk_i);
    rvalid_i = 1'b1;
    rid_i    = id;
    rdata_i  = data;
    #1;
    check("valid_o", valid_o, live);
    if (live) begin
      check("trans_id_o", trans_id_o, pend_tid[id]);
      check("result_o", result_o,
            expected_result(data, pend_addr[id][ALIGN_W-1:0], pend_op[id]));
    end
    @(negedge clk_i);
    rvalid_i = 1'b0;
  endtask

  task automatic report(input string name, input int err0);
    $display("%s test finished with %0d errors", name, n_errors - err0);
  endtask

  // --------------------------------------
  // tests
  // --------------------------------------
  task automatic test_extension();
    int        err0;
    int        max_off;
    ld_op_e    op;
    ldbuf_id_t id;
    err0 = n_errors;
    for (int i = 0; i < 7; i++) begin
      op = ld_op_e'(i);
      case (op)
        LD:       max_off = 0;
        LW, LWU:  max_off = 4;
        LH, LHU:  max_off = 6;
        default:  max_off = 7;
      endcase
      for (int off = 0; off <= max_off; off++) begin
        issue_load(random_addr(off), op, 0, id);
        respond(id, 1'b1);
      end
    end
    report("extension", err0);
  endtask

  task automatic test_grant_wait();
    int        err0;
    ldbuf_id_t id;
    err0 = n_errors;
    for (int k = 0; k < 4; k++) begin
      issue_load(random_addr(0), ld_op_e'($urandom % 7), $urandom % 6 + 1, id);
      respond(id, 1'b1);
    end
    report("grant wait", err0);
  endtask

  task automatic test_page_stall();
    int              err0;
    logic [VLEN-1:0] addr;
    ldbuf_id_t       id;
    err0 = n_errors;
    addr = random_addr(2);
    start_load(addr, LH, 0);
    page_offset_matches_i = 1'b1;
    // pending store on the same offset holds the request back
    for (int k = 0; k < 5; k++) begin
      #1;
      check("req_o", req_o, 0);
      check("pop_o", pop_o, 0);
      check("page_offset_o", page_offset_o, addr[11:0]);
      @(negedge clk_i);
    end
    page_offset_matches_i = 1'b0;
    complete_load(0, id);
    respond(id, 1'b1);
    report("page offset stall", err0);
  endtask

  task automatic test_outstanding();
    int        err0;
    ldbuf_id_t ids [5];
    err0 = n_errors;
    for (int k = 0; k < 4; k++) begin
      issue_load(random_addr(0), ld_op_e'(k), 0, ids[k]);
      check("id_o", ids[k], k);
    end
    // fifth load must wait while the buffer is full
    start_load(random_addr(1), LBU, 0);
    for (int k = 0; k < 3; k++) begin
      #1;
      check("req_o", req_o, 0);
      check("pop_o", pop_o, 0);
      @(negedge clk_i);
    end
    respond(ids[3], 1'b1);
    complete_load(0, ids[4]);
    check("id_o", ids[4], ids[3]);
    for (int k = 2; k >= 0; k--) begin
      respond(ids[k], 1'b1);
    end
    respond(ids[4], 1'b1);
    report("outstanding loads", err0);
  endtask

  task automatic test_flush();
    int        err0;
    ldbuf_id_t id_a;
    ldbuf_id_t id_b;
    ldbuf_id_t id_c;
    err0 = n_errors;
    issue_load(random_addr(4), LW, 0, id_a);
    issue_load(random_addr(6), LHU, 1, id_b);
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    #1;
    // kill cycle right after the flush
    check("tag_valid_o", tag_valid_o, 1);
    check("kill_o", kill_o, 1);
    respond(id_a, 1'b0);
    respond(id_b, 1'b0);
    issue_load(random_addr(3), LB, 2, id_c);
    respond(id_c, 1'b1);
    report("flush", err0);
  endtask

  // --------------------------------------
  // main sequence
  // --------------------------------------
  initial begin
    void'($urandom(32'ha4cd_8e97));
    n_checks              = 0;
    n_errors              = 0;
    next_tid              = '0;
    rst_ni                = 1'b0;
    flush_i               = 1'b0;
    valid_i               = 1'b0;
    vaddr_i               = '0;
    op_i                  = LD;
    trans_id_i            = '0;
    page_offset_matches_i = 1'b0;
    gnt_i                 = 1'b0;
    rvalid_i              = 1'b0;
    rid_i                 = '0;
    rdata_i               = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check("req_o", req_o, 0);
    check("pop_o", pop_o, 0);
    check("tag_valid_o", tag_valid_o, 0);
    check("kill_o", kill_o, 0);
    check("valid_o", valid_o, 0);

    test_extension();
    test_grant_wait();
    test_page_stall();
    test_outstanding();
    test_flush();

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/ld_cfg_pkg.sv
rtl/ld_op_pkg.sv
rtl/ld_req_fsm.sv
rtl/ld_buffer.sv
rtl/ld_result_align.sv
rtl/load_unit_top.sv
tests/tb_load_unit.sv
